//--- hdl/fpga_axi_pkg.sv
/*
  Shared widths, codes and types of the on-chip AXI4 slave.
  The RAM is mapped from address 0. Only full-width FIXED and INCR
  bursts inside the RAM are served, everything else gets SLVERR.
*/
`default_nettype none

package fpga_axi_pkg;

  localparam int ID_W        = 2;
  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 64;
  localparam int STRB_W      = DATA_W / 8;
  localparam int BYTE_OFS_W  = $clog2(STRB_W);
  localparam int MEM_WORDS   = 1024;
  localparam int WORD_ADDR_W = $clog2(MEM_WORDS);
  localparam int LOCK_CYCLES = 16;

  localparam logic [1:0] BURST_FIXED = 2'd0;
  localparam logic [1:0] BURST_INCR  = 2'd1;
  localparam logic [1:0] BURST_WRAP  = 2'd2;

  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_SLVERR = 2'd2;

  // 8 bytes per beat
  localparam logic [2:0] SIZE_FULL = 3'd3;

  typedef logic [ID_W-1:0]        axi_id_t;
  typedef logic [ADDR_W-1:0]      axi_addr_t;
  typedef logic [DATA_W-1:0]      axi_data_t;
  typedef logic [STRB_W-1:0]      axi_strb_t;
  typedef logic [7:0]             axi_len_t;
  typedef logic [1:0]             axi_resp_t;
  typedef logic [WORD_ADDR_W-1:0] word_addr_t;

  // Burst check, evaluated once when the address is accepted
  function automatic logic burst_error(input axi_addr_t addr, input axi_len_t len,
                                       input logic [2:0] size, input logic [1:0] burst);
    axi_addr_t first_word;
    axi_addr_t last_word;
    logic      bad_type;
    first_word = addr >> BYTE_OFS_W;
    last_word  = first_word;
    bad_type   = 1'b0;
    case (burst)
      BURST_FIXED: last_word = first_word;
      BURST_INCR:  last_word = first_word + ADDR_W'(len);
      BURST_WRAP:  bad_type = 1'b1;
      default:     bad_type = 1'b1;
    endcase
    return bad_type || (size != SIZE_FULL) || (addr[BYTE_OFS_W-1:0] != '0) ||
           (last_word >= ADDR_W'(MEM_WORDS));
  endfunction

endpackage

`default_nettype wire

//--- hdl/clock_reset_ctrl.sv
/*
  Stand-in for the vendor PLL lock. Lock and fabric reset release
  come LOCK_CYCLES edges after arst_n rises, synchroniser included.
*/
`default_nettype none

module clock_reset_ctrl (
  input  wire logic clk,
  input  wire logic arst_n,
  output logic      pll_locked,
  output logic      fabric_rst_n
);

  localparam int CNT_W = $clog2(fpga_axi_pkg::LOCK_CYCLES);

  logic [1:0]       sync_q;
  logic [CNT_W-1:0] cnt_q;
  logic             locked_q;

  // Two synchroniser edges plus the final lock edge come out of the count
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_q   <= 2'b00;
      cnt_q    <= '0;
      locked_q <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
      if (sync_q[1] && !locked_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == CNT_W'(fpga_axi_pkg::LOCK_CYCLES - 3)) begin
          locked_q <= 1'b1;
        end
      end
    end
  end

  assign pll_locked   = locked_q;
  assign fabric_rst_n = locked_q;

endmodule

`default_nettype wire

//--- hdl/axi_write_ctrl.sv
/*
  AXI4 write channel engine, one burst at a time.
  The burst ends on wlast; awlen only feeds the range check.
  A new AW waits until the B handshake of the previous burst.
*/
`default_nettype none

module axi_write_ctrl (
  input  wire logic                     clk,
  input  wire logic                     fabric_rst_n,
  input  wire fpga_axi_pkg::axi_id_t    awid,
  input  wire fpga_axi_pkg::axi_addr_t  awaddr,
  input  wire fpga_axi_pkg::axi_len_t   awlen,
  input  wire logic [2:0]               awsize,
  input  wire logic [1:0]               awburst,
  input  wire logic                     awvalid,
  output logic                          awready,
  input  wire fpga_axi_pkg::axi_data_t  wdata,
  input  wire fpga_axi_pkg::axi_strb_t  wstrb,
  input  wire logic                     wlast,
  input  wire logic                     wvalid,
  output logic                          wready,
  output fpga_axi_pkg::axi_id_t         bid,
  output fpga_axi_pkg::axi_resp_t       bresp,
  output logic                          bvalid,
  input  wire logic                     bready,
  output logic                          wr_en,
  output fpga_axi_pkg::word_addr_t      wr_addr,
  output fpga_axi_pkg::axi_data_t       wr_data,
  output fpga_axi_pkg::axi_strb_t       wr_strb
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_DATA,
    S_RESP
  } wr_state_t;

  wr_state_t                state_q;
  wr_state_t                state_d;
  logic                     aw_ready_q;
  logic                     aw_hs;
  logic                     w_hs;
  logic                     b_hs;
  logic                     err_q;
  logic                     fixed_q;
  fpga_axi_pkg::axi_id_t    id_q;
  fpga_axi_pkg::word_addr_t waddr_q;

  assign aw_hs = awvalid && aw_ready_q;
  assign w_hs  = wvalid && wready;
  assign b_hs  = bvalid && bready;

  assign awready = aw_ready_q;
  assign wready  = (state_q == S_DATA);
  assign bvalid  = (state_q == S_RESP);
  assign bid     = id_q;
  assign bresp   = err_q ? fpga_axi_pkg::RESP_SLVERR : fpga_axi_pkg::RESP_OKAY;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (aw_hs) begin
          state_d = S_DATA;
        end
      end
      S_DATA: begin
        if (w_hs && wlast) begin
          state_d = S_RESP;
        end
      end
      S_RESP: begin
        if (b_hs) begin
          state_d = S_IDLE;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  // awready is registered so it stays low through the fabric reset
  always_ff @(posedge clk or negedge fabric_rst_n) begin
    if (!fabric_rst_n) begin
      state_q    <= S_IDLE;
      aw_ready_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      aw_ready_q <= (state_d == S_IDLE);
    end
  end

  // Burst attributes, latched at AW acceptance
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      id_q    <= awid;
      fixed_q <= (awburst == fpga_axi_pkg::BURST_FIXED);
      err_q   <= fpga_axi_pkg::burst_error(awaddr, awlen, awsize, awburst);
      waddr_q <= awaddr[fpga_axi_pkg::BYTE_OFS_W +: fpga_axi_pkg::WORD_ADDR_W];
    end else if (w_hs && !fixed_q) begin
      waddr_q <= waddr_q + 1'b1;
    end
  end

  // Erroring bursts drain their beats without touching the RAM
  assign wr_en   = w_hs && !err_q;
  assign wr_addr = waddr_q;
  assign wr_data = wdata;
  assign wr_strb = wstrb;

endmodule

`default_nettype wire

//--- hdl/axi_read_ctrl.sv
/*
  AXI4 read channel engine, one burst at a time.
  First beat comes 2 cycles after AR; then one beat per cycle.
  The RAM output itself is the R data register, stalled via rd_en.
*/
`default_nettype none

module axi_read_ctrl (
  input  wire logic                     clk,
  input  wire logic                     fabric_rst_n,
  input  wire fpga_axi_pkg::axi_id_t    arid,
  input  wire fpga_axi_pkg::axi_addr_t  araddr,
  input  wire fpga_axi_pkg::axi_len_t   arlen,
  input  wire logic [2:0]               arsize,
  input  wire logic [1:0]               arburst,
  input  wire logic                     arvalid,
  output logic                          arready,
  output fpga_axi_pkg::axi_id_t         rid,
  output fpga_axi_pkg::axi_data_t       rdata,
  output fpga_axi_pkg::axi_resp_t       rresp,
  output logic                          rlast,
  output logic                          rvalid,
  input  wire logic                     rready,
  output logic                          rd_en,
  output fpga_axi_pkg::word_addr_t      rd_addr,
  input  wire fpga_axi_pkg::axi_data_t  rd_data
);

  // Holds len+1, up to 256 beats
  typedef logic [8:0] beat_cnt_t;

  beat_cnt_t                fetch_q;
  beat_cnt_t                deliver_q;
  beat_cnt_t                deliver_d;
  beat_cnt_t                burst_beats;
  logic                     ar_ready_q;
  logic                     rvalid_q;
  logic                     ar_hs;
  logic                     r_hs;
  logic                     err_q;
  logic                     fixed_q;
  fpga_axi_pkg::axi_id_t    id_q;
  fpga_axi_pkg::word_addr_t raddr_q;

  assign burst_beats = {1'b0, arlen} + 9'd1;
  assign ar_hs       = arvalid && ar_ready_q;
  assign r_hs        = rvalid_q && rready;

  // Fetch when the output beat is empty or leaving this cycle
  assign rd_en   = (fetch_q != '0) && (!rvalid_q || rready);
  assign rd_addr = raddr_q;

  assign arready = ar_ready_q;
  assign rvalid  = rvalid_q;
  assign rlast   = rvalid_q && (deliver_q == 9'd1);
  assign rid     = id_q;
  assign rdata   = err_q ? '0 : rd_data;
  assign rresp   = err_q ? fpga_axi_pkg::RESP_SLVERR : fpga_axi_pkg::RESP_OKAY;

  // AR is only taken when nothing is left to deliver
  always_comb begin
    deliver_d = deliver_q;
    if (ar_hs) begin
      deliver_d = burst_beats;
    end else if (r_hs) begin
      deliver_d = deliver_q - 9'd1;
    end
  end

  always_ff @(posedge clk or negedge fabric_rst_n) begin
    if (!fabric_rst_n) begin
      fetch_q    <= '0;
      deliver_q  <= '0;
      rvalid_q   <= 1'b0;
      ar_ready_q <= 1'b0;
    end else begin
      deliver_q  <= deliver_d;
      ar_ready_q <= (deliver_d == '0);
      if (ar_hs) begin
        fetch_q <= burst_beats;
      end else if (rd_en) begin
        fetch_q <= fetch_q - 9'd1;
      end
      if (rd_en) begin
        rvalid_q <= 1'b1;
      end else if (r_hs) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      id_q    <= arid;
      fixed_q <= (arburst == fpga_axi_pkg::BURST_FIXED);
      err_q   <= fpga_axi_pkg::burst_error(araddr, arlen, arsize, arburst);
      raddr_q <= araddr[fpga_axi_pkg::BYTE_OFS_W +: fpga_axi_pkg::WORD_ADDR_W];
    end else if (rd_en && !fixed_q) begin
      raddr_q <= raddr_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/axi_ram.sv
/*
  Simple dual-port RAM of 64-bit words with byte enables.
  No reset, contents start undefined. A read of the word being
  written in the same cycle returns the old data.
*/
`default_nettype none

module axi_ram (
  input  wire logic                     clk,
  input  wire logic                     wr_en,
  input  wire fpga_axi_pkg::word_addr_t wr_addr,
  input  wire fpga_axi_pkg::axi_data_t  wr_data,
  input  wire fpga_axi_pkg::axi_strb_t  wr_strb,
  input  wire logic                     rd_en,
  input  wire fpga_axi_pkg::word_addr_t rd_addr,
  output fpga_axi_pkg::axi_data_t       rd_data
);

  fpga_axi_pkg::axi_data_t mem [fpga_axi_pkg::MEM_WORDS];

  // Byte lanes written independently
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < fpga_axi_pkg::STRB_W; b++) begin
        if (wr_strb[b]) begin
          mem[wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
  end

  // Output holds while rd_en is low
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- hdl/fpga_top.sv
/*
  Board-level memory subsystem seen by the core's AXI4 master port.
  The port is dead until pll_locked rises. No lock, cache, prot,
  qos or region sidebands are provided.
*/
`default_nettype none

module fpga_top (
  input  wire logic                     clk,
  input  wire logic                     arst_n,
  output logic                          pll_locked,
  input  wire fpga_axi_pkg::axi_id_t    axi_awid,
  input  wire fpga_axi_pkg::axi_addr_t  axi_awaddr,
  input  wire fpga_axi_pkg::axi_len_t   axi_awlen,
  input  wire logic [2:0]               axi_awsize,
  input  wire logic [1:0]               axi_awburst,
  input  wire logic                     axi_awvalid,
  output logic                          axi_awready,
  input  wire fpga_axi_pkg::axi_data_t  axi_wdata,
  input  wire fpga_axi_pkg::axi_strb_t  axi_wstrb,
  input  wire logic                     axi_wlast,
  input  wire logic                     axi_wvalid,
  output logic                          axi_wready,
  output fpga_axi_pkg::axi_id_t         axi_bid,
  output fpga_axi_pkg::axi_resp_t       axi_bresp,
  output logic                          axi_bvalid,
  input  wire logic                     axi_bready,
  input  wire fpga_axi_pkg::axi_id_t    axi_arid,
  input  wire fpga_axi_pkg::axi_addr_t  axi_araddr,
  input  wire fpga_axi_pkg::axi_len_t   axi_arlen,
  input  wire logic [2:0]               axi_arsize,
  input  wire logic [1:0]               axi_arburst,
  input  wire logic                     axi_arvalid,
  output logic                          axi_arready,
  output fpga_axi_pkg::axi_id_t         axi_rid,
  output fpga_axi_pkg::axi_data_t       axi_rdata,
  output fpga_axi_pkg::axi_resp_t       axi_rresp,
  output logic                          axi_rlast,
  output logic                          axi_rvalid,
  input  wire logic                     axi_rready
);

  logic                     fabric_rst_n;
  logic                     wr_en;
  fpga_axi_pkg::word_addr_t wr_addr;
  fpga_axi_pkg::axi_data_t  wr_data;
  fpga_axi_pkg::axi_strb_t  wr_strb;
  logic                     rd_en;
  fpga_axi_pkg::word_addr_t rd_addr;
  fpga_axi_pkg::axi_data_t  rd_data;

  clock_reset_ctrl clock_reset_ctrl_0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .pll_locked  (pll_locked),
    .fabric_rst_n(fabric_rst_n)
  );

  // Write side
  axi_write_ctrl axi_write_ctrl_0 (
    .clk         (clk),
    .fabric_rst_n(fabric_rst_n),
    .awid        (axi_awid),
    .awaddr      (axi_awaddr),
    .awlen       (axi_awlen),
    .awsize      (axi_awsize),
    .awburst     (axi_awburst),
    .awvalid     (axi_awvalid),
    .awready     (axi_awready),
    .wdata       (axi_wdata),
    .wstrb       (axi_wstrb),
    .wlast       (axi_wlast),
    .wvalid      (axi_wvalid),
    .wready      (axi_wready),
    .bid         (axi_bid),
    .bresp       (axi_bresp),
    .bvalid      (axi_bvalid),
    .bready      (axi_bready),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .wr_strb     (wr_strb)
  );

  // Read side
  axi_read_ctrl axi_read_ctrl_0 (
    .clk         (clk),
    .fabric_rst_n(fabric_rst_n),
    .arid        (axi_arid),
    .araddr      (axi_araddr),
    .arlen       (axi_arlen),
    .arsize      (axi_arsize),
    .arburst     (axi_arburst),
    .arvalid     (axi_arvalid),
    .arready     (axi_arready),
    .rid         (axi_rid),
    .rdata       (axi_rdata),
    .rresp       (axi_rresp),
    .rlast       (axi_rlast),
    .rvalid      (axi_rvalid),
    .rready      (axi_rready),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data)
  );

  axi_ram axi_ram_0 (
    .clk    (clk),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .wr_strb(wr_strb),
    .rd_en  (rd_en),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

endmodule

`default_nettype wire

//--- test/axi_properties.sv
/*
  AXI handshake rules checked on the fpga_top port.
  Bound into every fpga_top instance. Failures are counted in fail_count.
*/
`default_nettype none

module axi_properties (
  input wire logic                    clk,
  input wire logic                    pll_locked,
  input wire logic                    axi_awready,
  input wire logic                    axi_wready,
  input wire logic                    axi_bvalid,
  input wire logic                    axi_bready,
  input wire fpga_axi_pkg::axi_id_t   axi_bid,
  input wire fpga_axi_pkg::axi_resp_t axi_bresp,
  input wire logic                    axi_arready,
  input wire logic                    axi_rvalid,
  input wire logic                    axi_rready,
  input wire fpga_axi_pkg::axi_id_t   axi_rid,
  input wire fpga_axi_pkg::axi_data_t axi_rdata,
  input wire fpga_axi_pkg::axi_resp_t axi_rresp,
  input wire logic                    axi_rlast
);

  int fail_count = 0;

  // B stays up with the same payload until bready
  b_hold_a: assert property (@(posedge clk) disable iff (!pll_locked)
    (axi_bvalid && !axi_bready) |=> (axi_bvalid && $stable(axi_bid) && $stable(axi_bresp)))
    else begin
      $error("B dropped or changed before its handshake");
      fail_count++;
    end

  // Same for R
  r_hold_a: assert property (@(posedge clk) disable iff (!pll_locked)
    (axi_rvalid && !axi_rready) |=> (axi_rvalid && $stable(axi_rid) && $stable(axi_rdata) &&
                                     $stable(axi_rresp) && $stable(axi_rlast)))
    else begin
      $error("R dropped or changed before its handshake");
      fail_count++;
    end

  rlast_a: assert property (@(posedge clk) axi_rlast |-> axi_rvalid)
    else begin
      $error("rlast high without rvalid");
      fail_count++;
    end

  // Pending B blocks the next write address
  aw_blocked_a: assert property (@(posedge clk) !(axi_awready && axi_bvalid))
    else begin
      $error("awready high while bvalid is pending");
      fail_count++;
    end

  quiet_before_lock_a: assert property (@(posedge clk)
    !pll_locked |-> !(axi_awready || axi_wready || axi_bvalid || axi_arready || axi_rvalid))
    else begin
      $error("AXI ready or valid high before lock");
      fail_count++;
    end

endmodule

bind fpga_top axi_properties axi_props_i (.*);

`default_nettype wire

//--- test/tb_fpga_top.sv
/*
  Directed tests of fpga_top acting as the AXI master.
  Expected data comes from a word model that applies strobes and the
  SLVERR rule. Tests only read words they have written before.
*/
`default_nettype none

module tb_fpga_top;

  localparam int WAIT_LIMIT = 100;

  logic                     clk;
  logic                     arst_n;
  logic                     pll_locked;
  fpga_axi_pkg::axi_id_t    axi_awid;
  fpga_axi_pkg::axi_addr_t  axi_awaddr;
  fpga_axi_pkg::axi_len_t   axi_awlen;
  logic [2:0]               axi_awsize;
  logic [1:0]               axi_awburst;
  logic                     axi_awvalid;
  logic                     axi_awready;
  fpga_axi_pkg::axi_data_t  axi_wdata;
  fpga_axi_pkg::axi_strb_t  axi_wstrb;
  logic                     axi_wlast;
  logic                     axi_wvalid;
  logic                     axi_wready;
  fpga_axi_pkg::axi_id_t    axi_bid;
  fpga_axi_pkg::axi_resp_t  axi_bresp;
  logic                     axi_bvalid;
  logic                     axi_bready;
  fpga_axi_pkg::axi_id_t    axi_arid;
  fpga_axi_pkg::axi_addr_t  axi_araddr;
  fpga_axi_pkg::axi_len_t   axi_arlen;
  logic [2:0]               axi_arsize;
  logic [1:0]               axi_arburst;
  logic                     axi_arvalid;
  logic                     axi_arready;
  fpga_axi_pkg::axi_id_t    axi_rid;
  fpga_axi_pkg::axi_data_t  axi_rdata;
  fpga_axi_pkg::axi_resp_t  axi_rresp;
  logic                     axi_rlast;
  logic                     axi_rvalid;
  logic                     axi_rready;

  integer                   seed;
  fpga_axi_pkg::axi_data_t  beat_data [256];
  fpga_axi_pkg::axi_strb_t  beat_strb [256];
  // Reference memory, keyed by word index
  fpga_axi_pkg::axi_data_t  model_mem [int];

  fpga_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_on_error();
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at the first failure");
  endtask

  task automatic timeout_fail(input string what);
    $display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
    stop_on_error();
  endtask

  task automatic check_data(input string what, input fpga_axi_pkg::axi_data_t got,
                            input fpga_axi_pkg::axi_data_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_resp(input string what, input fpga_axi_pkg::axi_resp_t got,
                            input fpga_axi_pkg::axi_resp_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_id(input string what, input fpga_axi_pkg::axi_id_t got,
                          input fpga_axi_pkg::axi_id_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_port_idle();
    check_bit("awready before lock", axi_awready, 1'b0);
    check_bit("wready before lock", axi_wready, 1'b0);
    check_bit("bvalid before lock", axi_bvalid, 1'b0);
    check_bit("arready before lock", axi_arready, 1'b0);
    check_bit("rvalid before lock", axi_rvalid, 1'b0);
  endtask

  function automatic fpga_axi_pkg::axi_data_t rand_word();
    return {32'($random(seed)), 32'($random(seed))};
  endfunction

  // SLVERR rule: bad type, narrow size, misaligned, or past the RAM end
  function automatic logic slverr_expected(input fpga_axi_pkg::axi_addr_t addr,
                                           input fpga_axi_pkg::axi_len_t len,
                                           input logic [2:0] size, input logic [1:0] burst);
    int unsigned first;
    first = addr >> 3;
    if (burst != fpga_axi_pkg::BURST_FIXED && burst != fpga_axi_pkg::BURST_INCR) begin
      return 1'b1;
    end
    if (size != fpga_axi_pkg::SIZE_FULL || addr[2:0] != 3'd0) begin
      return 1'b1;
    end
    if (burst == fpga_axi_pkg::BURST_INCR) begin
      return (first + 32'(len)) >= fpga_axi_pkg::MEM_WORDS;
    end
    return first >= fpga_axi_pkg::MEM_WORDS;
  endfunction

  function automatic fpga_axi_pkg::axi_data_t merge_bytes(
      input fpga_axi_pkg::axi_data_t old_word, input fpga_axi_pkg::axi_data_t new_word,
      input fpga_axi_pkg::axi_strb_t strb);
    fpga_axi_pkg::axi_data_t result;
    result = old_word;
    for (int b = 0; b < fpga_axi_pkg::STRB_W; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  // Beats come from beat_data and beat_strb, B is held off for bready_delay cycles
  task automatic axi_write_burst(input fpga_axi_pkg::axi_id_t id,
                                 input fpga_axi_pkg::axi_addr_t addr,
                                 input fpga_axi_pkg::axi_len_t len, input logic [2:0] size,
                                 input logic [1:0] burst, input int bready_delay);
    int                      waited;
    int                      idx;
    logic                    err;
    fpga_axi_pkg::axi_resp_t exp_resp;
    err      = slverr_expected(addr, len, size, burst);
    exp_resp = err ? fpga_axi_pkg::RESP_SLVERR : fpga_axi_pkg::RESP_OKAY;
    idx      = int'(addr >> 3);
    @(posedge clk);
    axi_awid    <= id;
    axi_awaddr  <= addr;
    axi_awlen   <= len;
    axi_awsize  <= size;
    axi_awburst <= burst;
    axi_awvalid <= 1'b1;
    waited = 0;
    @(negedge clk);
    while (!axi_awready) begin
      if (waited == WAIT_LIMIT) begin
        timeout_fail("awready");
      end
      waited++;
      @(negedge clk);
    end
    @(posedge clk);
    axi_awvalid <= 1'b0;
    for (int beat = 0; beat <= int'(len); beat++) begin
      axi_wdata  <= beat_data[beat];
      axi_wstrb  <= beat_strb[beat];
      axi_wlast  <= (beat == int'(len));
      axi_wvalid <= 1'b1;
      waited = 0;
      @(negedge clk);
      while (!axi_wready) begin
        if (waited == WAIT_LIMIT) begin
          timeout_fail("wready");
        end
        waited++;
        @(negedge clk);
      end
      // Beat is taken on the coming edge
      if (!err) begin
        model_mem[idx] = merge_bytes(model_mem.exists(idx) ? model_mem[idx] : '0,
                                     beat_data[beat], beat_strb[beat]);
      end
      if (burst == fpga_axi_pkg::BURST_INCR) begin
        idx++;
      end
      @(posedge clk);
    end
    axi_wvalid <= 1'b0;
    axi_wlast  <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (!axi_bvalid) begin
      if (waited == WAIT_LIMIT) begin
        timeout_fail("bvalid");
      end
      waited++;
      @(negedge clk);
    end
    check_id("bid", axi_bid, id);
    check_resp("bresp", axi_bresp, exp_resp);
    repeat (bready_delay) begin
      @(posedge clk);
      @(negedge clk);
      check_bit("bvalid while held", axi_bvalid, 1'b1);
      check_id("bid while held", axi_bid, id);
      check_resp("bresp while held", axi_bresp, exp_resp);
      check_bit("awready while B pending", axi_awready, 1'b0);
    end
    @(posedge clk);
    axi_bready <= 1'b1;
    @(negedge clk);
    @(posedge clk);
    axi_bready <= 1'b0;
    @(negedge clk);
    check_bit("bvalid after B handshake", axi_bvalid, 1'b0);
    check_bit("awready after B handshake", axi_awready, 1'b1);
  endtask

  task automatic axi_read_burst(input fpga_axi_pkg::axi_id_t id,
                                input fpga_axi_pkg::axi_addr_t addr,
                                input fpga_axi_pkg::axi_len_t len, input logic [2:0] size,
                                input logic [1:0] burst, input bit random_ready);
    int                      waited;
    int                      beat;
    int                      idx;
    logic                    err;
    fpga_axi_pkg::axi_resp_t exp_resp;
    fpga_axi_pkg::axi_data_t exp_data;
    err      = slverr_expected(addr, len, size, burst);
    exp_resp = err ? fpga_axi_pkg::RESP_SLVERR : fpga_axi_pkg::RESP_OKAY;
    idx      = int'(addr >> 3);
    @(posedge clk);
    axi_arid    <= id;
    axi_araddr  <= addr;
    axi_arlen   <= len;
    axi_arsize  <= size;
    axi_arburst <= burst;
    axi_arvalid <= 1'b1;
    waited = 0;
    @(negedge clk);
    while (!axi_arready) begin
      if (waited == WAIT_LIMIT) begin
        timeout_fail("arready");
      end
      waited++;
      @(negedge clk);
    end
    @(posedge clk);
    axi_arvalid <= 1'b0;
    beat   = 0;
    waited = 0;
    while (beat <= int'(len)) begin
      @(posedge clk);
      axi_rready <= random_ready ? (($random(seed) & 3) != 0) : 1'b1;
      @(negedge clk);
      if (axi_rvalid && axi_rready) begin
        if (!err && !model_mem.exists(idx)) begin
          $display("Test reads word %0d, which was never written", idx);
          stop_on_error();
        end
        if (err) begin
          exp_data = '0;
        end else begin
          exp_data = model_mem[idx];
        end
        check_data($sformatf("rdata beat %0d", beat), axi_rdata, exp_data);
        check_resp("rresp", axi_rresp, exp_resp);
        check_id("rid", axi_rid, id);
        check_bit($sformatf("rlast beat %0d", beat), axi_rlast, beat == int'(len));
        beat++;
        if (burst == fpga_axi_pkg::BURST_INCR) begin
          idx++;
        end
        waited = 0;
      end else begin
        if (waited == WAIT_LIMIT) begin
          timeout_fail("an R beat");
        end
        waited++;
      end
    end
    @(posedge clk);
    axi_rready <= 1'b0;
    @(negedge clk);
    check_bit("rvalid after rlast", axi_rvalid, 1'b0);
    check_bit("arready after rlast", axi_arready, 1'b1);
  endtask

  task automatic test_reset_lock();
    repeat (5) begin
      @(posedge clk);
      @(negedge clk);
      check_bit("pll_locked in reset", pll_locked, 1'b0);
      check_port_idle();
    end
    @(posedge clk);
    arst_n <= 1'b1;
    for (int n = 1; n <= fpga_axi_pkg::LOCK_CYCLES; n++) begin
      @(posedge clk);
      @(negedge clk);
      check_bit($sformatf("pll_locked after %0d edges", n), pll_locked,
                n == fpga_axi_pkg::LOCK_CYCLES);
      // Port stays quiet only until lock
      if (n < fpga_axi_pkg::LOCK_CYCLES) begin
        check_port_idle();
      end
    end
  endtask

  task automatic test_single_beats();
    fpga_axi_pkg::axi_strb_t strbs [3];
    strbs = '{8'h0F, 8'hA5, 8'h80};
    beat_strb[0] = 8'hFF;
    for (int i = 0; i < 3; i++) begin
      beat_data[0] = rand_word();
      axi_write_burst(2'(i), 32'h100 + 32'(8*i), 8'd0, fpga_axi_pkg::SIZE_FULL,
                      fpga_axi_pkg::BURST_INCR, 0);
    end
    // Partial strobes over the words just written
    for (int i = 0; i < 3; i++) begin
      beat_data[0] = rand_word();
      beat_strb[0] = strbs[i];
      axi_write_burst(2'(i + 1), 32'h100 + 32'(8*i), 8'd0, fpga_axi_pkg::SIZE_FULL,
                      fpga_axi_pkg::BURST_INCR, 1);
    end
    for (int i = 0; i < 3; i++) begin
      axi_read_burst(2'(3 - i), 32'h100 + 32'(8*i), 8'd0, fpga_axi_pkg::SIZE_FULL,
                     fpga_axi_pkg::BURST_INCR, 1'b0);
    end
  endtask

  task automatic test_incr_stream();
    for (int i = 0; i < 16; i++) begin
      beat_data[i] = rand_word();
      beat_strb[i] = 8'hFF;
    end
    axi_write_burst(2'd1, 32'h400, 8'd15, fpga_axi_pkg::SIZE_FULL, fpga_axi_pkg::BURST_INCR, 0);
    axi_read_burst(2'd2, 32'h400, 8'd15, fpga_axi_pkg::SIZE_FULL, fpga_axi_pkg::BURST_INCR, 1'b1);
  endtask

  task automatic test_fixed_burst();
    beat_data[0] = rand_word();
    beat_strb[0] = 8'hFF;
    axi_write_burst(2'd0, 32'h800, 8'd0, fpga_axi_pkg::SIZE_FULL, fpga_axi_pkg::BURST_INCR, 0);
    beat_strb[0] = 8'h03;
    beat_strb[1] = 8'h0C;
    beat_strb[2] = 8'h3C;
    beat_strb[3] = 8'hF0;
    for (int i = 0; i < 4; i++) begin
      beat_data[i] = rand_word();
    end
    axi_write_burst(2'd2, 32'h800, 8'd3, fpga_axi_pkg::SIZE_FULL, fpga_axi_pkg::BURST_FIXED, 0);
    axi_read_burst(2'd1, 32'h800, 8'd0, fpga_axi_pkg::SIZE_FULL, fpga_axi_pkg::BURST_INCR, 1'b0);
    axi_read_burst(2'd3, 32'h800, 8'd3, fpga_axi_pkg::SIZE_FULL, fpga_axi_pkg::BURST_FIXED, 1'b1);
  endtask

  task automatic test_error_bursts();
    fpga_axi_pkg::axi_addr_t end_addr;
    end_addr = 32'((fpga_axi_pkg::MEM_WORDS - 2) * 8);
    for (int i = 0; i < 4; i++) begin
      beat_data[i] = rand_word();
      beat_strb[i] = 8'hFF;
    end
    axi_write_burst(2'd0, 32'h100, 8'd3, fpga_axi_pkg::SIZE_FULL, fpga_axi_pkg::BURST_WRAP, 0);
    axi_write_burst(2'd1, 32'h108, 8'd1, 3'd2, fpga_axi_pkg::BURST_INCR, 0);
    axi_write_burst(2'd2, end_addr, 8'd3, fpga_axi_pkg::SIZE_FULL, fpga_axi_pkg::BURST_INCR, 0);
    axi_read_burst(2'd3, 32'h100, 8'd3, fpga_axi_pkg::SIZE_FULL, fpga_axi_pkg::BURST_WRAP, 1'b0);
    axi_read_burst(2'd2, 32'h108, 8'd1, 3'd2, fpga_axi_pkg::BURST_INCR, 1'b1);
    axi_read_burst(2'd1, end_addr, 8'd3, fpga_axi_pkg::SIZE_FULL, fpga_axi_pkg::BURST_INCR, 1'b0);
    // Words under the failed bursts keep their old contents
    axi_read_burst(2'd0, 32'h100, 8'd2, fpga_axi_pkg::SIZE_FULL, fpga_axi_pkg::BURST_INCR, 1'b0);
  endtask

  task automatic test_b_backpressure();
    int delay;
    delay = 8 + ($random(seed) & 15);
    for (int i = 0; i < 4; i++) begin
      beat_data[i] = rand_word();
      beat_strb[i] = 8'hFF;
    end
    // Read streams from another region while B is held
    fork
      axi_write_burst(2'd3, 32'h1000, 8'd3, fpga_axi_pkg::SIZE_FULL,
                      fpga_axi_pkg::BURST_INCR, delay);
      axi_read_burst(2'd1, 32'h400, 8'd15, fpga_axi_pkg::SIZE_FULL,
                     fpga_axi_pkg::BURST_INCR, 1'b1);
    join
    axi_read_burst(2'd0, 32'h1000, 8'd3, fpga_axi_pkg::SIZE_FULL, fpga_axi_pkg::BURST_INCR, 1'b0);
  endtask

  initial begin
    seed        = 32'h5563;
    arst_n      = 1'b0;
    axi_awid    = '0;
    axi_awaddr  = '0;
    axi_awlen   = '0;
    axi_awsize  = '0;
    axi_awburst = '0;
    axi_awvalid = 1'b0;
    axi_wdata   = '0;
    axi_wstrb   = '0;
    axi_wlast   = 1'b0;
    axi_wvalid  = 1'b0;
    axi_bready  = 1'b0;
    axi_arid    = '0;
    axi_araddr  = '0;
    axi_arlen   = '0;
    axi_arsize  = '0;
    axi_arburst = '0;
    axi_arvalid = 1'b0;
    axi_rready  = 1'b0;
    test_reset_lock();
    test_single_beats();
    test_incr_stream();
    test_fixed_burst();
    test_error_bursts();
    test_b_backpressure();
    repeat (2) @(posedge clk);
    if (dut_i.axi_props_i.fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("%0d assertion failures", dut_i.axi_props_i.fail_count);
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
hdl/fpga_axi_pkg.sv
hdl/clock_reset_ctrl.sv
hdl/axi_write_ctrl.sv
hdl/axi_read_ctrl.sv
hdl/axi_ram.sv
hdl/fpga_top.sv
test/axi_properties.sv
test/tb_fpga_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fpga_top -f vlog.f -o tb_fpga_top
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_fpga_top > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Simulation finished: PASS$" sim.log; then
  exit 0
else
  echo "Pass message not found in sim.log"
  exit 1
fi
